// ==== hw/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Processor side widths
`define ADDR_WIDTH      32
`define DATA_WIDTH      32

// Byte lanes per data word
`define BE_WIDTH        (`DATA_WIDTH / 8)

// Backing memory decodes 12 byte address bits
`define MEM_ADDR_WIDTH  12

// Word index as carried in a request
`define WORD_IDX_WIDTH  (`MEM_ADDR_WIDTH - 2)

// Depth of the backing memory in words
`define MEM_WORDS       (1 << `WORD_IDX_WIDTH)

// Line counts per cache level, powers of two
`define L1_LINES        4
`define L2_LINES        16
`define L3_LINES        64

`endif

// ==== hw/mem_pkg.sv ====
package mem_pkg;

`include "mem_consts.svh"

    // Load/store size code, encoding follows the core's decoder
    typedef enum logic [2:0] {
        SIZE_B  = 3'd0,     // Signed byte
        SIZE_H  = 3'd1,     // Signed half
        SIZE_W  = 3'd2,
        SIZE_BU = 3'd4,     // Unsigned byte
        SIZE_HU = 3'd5      // Unsigned half
    } size_e;

    // Where a read was served from
    typedef enum logic [1:0] {
        HIT_L1,
        HIT_L2,
        HIT_L3,
        HIT_MEM
    } hit_level_e;

    typedef struct packed {
        logic                       write;
        logic [`WORD_IDX_WIDTH-1:0] word_idx;
        logic [`BE_WIDTH-1:0]       byte_en;    // Already shifted to the lane
        logic [`DATA_WIDTH-1:0]     wdata;      // Replicated into the lanes
        size_e                      size;
        logic [1:0]                 offset;
    } mem_req_t;

    typedef struct packed {
        logic                   hit;
        logic [`DATA_WIDTH-1:0] data;
    } lookup_t;

endpackage

// ==== hw/load_store_unit.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module load_store_unit import mem_pkg::*; (
    input  logic                    clk,
    input  logic                    access_i,
    input  logic                    mem_write_i,
    input  size_e                   size_src_i,
    input  logic [`ADDR_WIDTH-1:0]  addr_i,
    input  logic [`DATA_WIDTH-1:0]  write_data_i,
    input  logic [`DATA_WIDTH-1:0]  word_i,
    output mem_req_t                req_o,
    output logic [`DATA_WIDTH-1:0]  load_data_o
);
    logic [1:0]             offset;
    logic [`BE_WIDTH-1:0]   be_base;
    logic [`DATA_WIDTH-1:0] store_data;
    logic [`DATA_WIDTH-1:0] shifted_word;
    logic [7:0]             load_byte;
    logic [15:0]            load_half;

    assign offset = addr_i[1:0];

    // Enable pattern and lane replication by size
    always_comb begin
        case (size_src_i)
            SIZE_B, SIZE_BU: begin
                be_base    = 4'b0001;
                store_data = {4{write_data_i[7:0]}};
            end
            SIZE_H, SIZE_HU: begin
                be_base    = 4'b0011;
                store_data = {2{write_data_i[15:0]}};
            end
            SIZE_W: begin
                be_base    = 4'b1111;
                store_data = write_data_i;
            end
            default: begin
                be_base    = 4'b0000;   // Nothing gets written
                store_data = write_data_i;
            end
        endcase
    end

    assign req_o.write    = mem_write_i;
    assign req_o.word_idx = addr_i[`MEM_ADDR_WIDTH-1:2];
    assign req_o.byte_en  = be_base << offset;
    assign req_o.wdata    = store_data;
    assign req_o.size     = size_src_i;
    assign req_o.offset   = offset;

    // Load side
    assign shifted_word = word_i >> {req_o.offset, 3'b000};
    assign load_byte    = shifted_word[7:0];
    assign load_half    = req_o.offset[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (req_o.size)
            SIZE_B:  load_data_o = {{24{load_byte[7]}}, load_byte};
            SIZE_BU: load_data_o = {24'd0, load_byte};
            SIZE_H:  load_data_o = {{16{load_half[15]}}, load_half};
            SIZE_HU: load_data_o = {16'd0, load_half};
            default: load_data_o = word_i;
        endcase
    end

    a_size_known: assert property (@(posedge clk)
        access_i |-> size_src_i inside {SIZE_B, SIZE_H, SIZE_W, SIZE_BU, SIZE_HU});

    // Misaligned accesses are not supported anywhere in the hierarchy
    a_aligned: assert property (@(posedge clk)
        access_i |-> !((size_src_i == SIZE_H || size_src_i == SIZE_HU) && addr_i[0])
                  && !(size_src_i == SIZE_W && addr_i[1:0] != 2'b00));

endmodule

// ==== hw/cache_level.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module cache_level import mem_pkg::*; #(
    parameter int LINES = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        access_i,
    input  mem_req_t    req_i,
    input  lookup_t     below_i,
    output lookup_t     resolved_o,
    output logic        hit_o
);
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = `WORD_IDX_WIDTH - IDX_W;

    // Line storage
    logic [TAG_W-1:0]       tag_q  [LINES];
    logic [`DATA_WIDTH-1:0] data_q [LINES];
    logic [LINES-1:0]       valid_q;

    logic [IDX_W-1:0]       idx;
    logic [TAG_W-1:0]       tag;
    logic                   hit;
    logic                   fill;
    logic                   wr_hit;

    if ((1 << IDX_W) != LINES || IDX_W == 0) begin : g_bad_lines
        $error("cache_level: LINES must be a power of two above one");
    end

    assign idx = req_i.word_idx[IDX_W-1:0];
    assign tag = req_i.word_idx[`WORD_IDX_WIDTH-1:IDX_W];

    assign hit    = valid_q[idx] && (tag_q[idx] == tag);
    assign fill   = access_i && !req_i.write && !hit;  // Read miss allocates
    assign wr_hit = access_i && req_i.write && hit;    // Write miss does not

    // Own word on a hit, otherwise pass the lower level through
    assign resolved_o.hit  = hit | below_i.hit;
    assign resolved_o.data = hit ? data_q[idx] : below_i.data;
    assign hit_o           = hit;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= below_i.data;
        end else if (wr_hit) begin
            // Merge the enabled lanes in place
            for (int b = 0; b < `BE_WIDTH; b++) begin
                if (req_i.byte_en[b]) begin
                    data_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // A write leaves the set of valid lines untouched, so nothing was filled
    a_no_fill_on_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (access_i && req_i.write) |=> $stable(valid_q));

endmodule

// ==== hw/data_memory.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module data_memory import mem_pkg::*; (
    input  logic        clk,
    input  logic        access_i,
    input  mem_req_t    req_i,
    output lookup_t     rd_o
);
    logic [`DATA_WIDTH-1:0] mem_q [`MEM_WORDS];
    logic                   wr_en;

    // Memory starts out all zero
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // Every write goes through to here
    assign wr_en = access_i && req_i.write;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `BE_WIDTH; b++) begin
                if (req_i.byte_en[b]) begin
                    mem_q[req_i.word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Last level, always holds the word
    assign rd_o.hit  = 1'b1;
    assign rd_o.data = mem_q[req_i.word_idx];

endmodule

// ==== hw/memory_top.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module memory_top import mem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    access_i,
    input  logic                    mem_write_i,
    input  size_e                   size_src_i,
    input  logic [`ADDR_WIDTH-1:0]  addr_i,
    input  logic [`DATA_WIDTH-1:0]  write_data_i,
    output logic [`DATA_WIDTH-1:0]  read_data_o,
    output logic                    data_valid_o,
    output hit_level_e              hit_level_o
);
    mem_req_t               req;
    lookup_t                mem_rd;
    lookup_t                l3_res, l2_res, l1_res;
    logic                   l1_hit, l2_hit, l3_hit;
    logic [`DATA_WIDTH-1:0] load_data;
    hit_level_e             hit_level;
    logic                   rd_access;

    load_store_unit lsu0 (
        .clk          (clk),
        .access_i     (access_i),
        .mem_write_i  (mem_write_i),
        .size_src_i   (size_src_i),
        .addr_i       (addr_i),
        .write_data_i (write_data_i),
        .word_i       (l1_res.data),   // Final word out of the chain
        .req_o        (req),
        .load_data_o  (load_data)
    );

    cache_level #(.LINES(`L1_LINES)) l1_cache (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .access_i   (access_i),
        .req_i      (req),
        .below_i    (l2_res),
        .resolved_o (l1_res),
        .hit_o      (l1_hit)
    );

    cache_level #(.LINES(`L2_LINES)) l2_cache (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .access_i   (access_i),
        .req_i      (req),
        .below_i    (l3_res),
        .resolved_o (l2_res),
        .hit_o      (l2_hit)
    );

    cache_level #(.LINES(`L3_LINES)) l3_cache (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .access_i   (access_i),
        .req_i      (req),
        .below_i    (mem_rd),
        .resolved_o (l3_res),
        .hit_o      (l3_hit)
    );

    data_memory dmem0 (
        .clk      (clk),
        .access_i (access_i),
        .req_i    (req),
        .rd_o     (mem_rd)
    );

    // Nearest level wins
    assign hit_level = l1_hit ? HIT_L1 :
                       l2_hit ? HIT_L2 :
                       l3_hit ? HIT_L3 : HIT_MEM;

    assign rd_access = access_i && !mem_write_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_valid_o <= 1'b0;
            read_data_o  <= '0;
            hit_level_o  <= HIT_L1;
        end else begin
            data_valid_o <= rd_access;  // One pulse per read
            if (rd_access) begin
                read_data_o <= load_data;
                hit_level_o <= hit_level;
            end
        end
    end

    a_no_valid_after_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (access_i && mem_write_i) |=> !data_valid_o);

endmodule

// ==== testbench/tb_memory_top.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module tb_memory_top import mem_pkg::*; ();
    localparam string       VEC_FILE    = "testbench/access_input.txt";
    localparam int unsigned SEED        = 32'h18aa_7deb;
    localparam int          DRIVE_DELAY = 2;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    logic                   access_i;
    logic                   mem_write_i;
    size_e                  size_src_i;
    logic [`ADDR_WIDTH-1:0] addr_i;
    logic [`DATA_WIDTH-1:0] write_data_i;
    logic [`DATA_WIDTH-1:0] read_data_o;
    logic                   data_valid_o;
    hit_level_e             hit_level_o;

    // One entry per line of the vector file
    string                  vec_name  [$];
    bit                     vec_write [$];
    logic [2:0]             vec_size  [$];
    logic [`ADDR_WIDTH-1:0] vec_addr  [$];
    logic [`DATA_WIDTH-1:0] vec_wdata [$];
    logic [`DATA_WIDTH-1:0] vec_exp   [$];
    hit_level_e             vec_level [$];

    int          pass_count  = 0;
    int          fail_count  = 0;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;   // Zero until the vectors are loaded
    bit          load_ok;

    memory_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .access_i     (access_i),
        .mem_write_i  (mem_write_i),
        .size_src_i   (size_src_i),
        .addr_i       (addr_i),
        .write_data_i (write_data_i),
        .read_data_o  (read_data_o),
        .data_valid_o (data_valid_o),
        .hit_level_o  (hit_level_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Hit level column, -1 when the text is not a level
    function automatic int level_code(input string s);
        if (s == "L1") return 0;
        if (s == "L2") return 1;
        if (s == "L3") return 2;
        if (s == "MEM") return 3;
        return -1;
    endfunction

    // These tests go out with no idle cycle in front
    function automatic bit is_back_to_back(input string s);
        return s.substr(0, 2) == "b2b";
    endfunction

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        int          lvl;
        string       line;
        string       name_s;
        string       op_s;
        string       lvl_s;
        logic [31:0] size_v;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] exp_v;
        ok = 1;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            ok = 0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
            n = $sscanf(line, "%s %s %h %h %h %h %s",
                        name_s, op_s, size_v, addr_v, wdata_v, exp_v, lvl_s);
            lvl = level_code(lvl_s);
            if (n != 7 || !(op_s == "R" || op_s == "W") || (op_s == "R" && lvl < 0)) begin
                $display("Malformed line in %0s: %0s", VEC_FILE, line);
                ok = 0;
                continue;
            end
            vec_name.push_back(name_s);
            vec_write.push_back(op_s == "W");
            vec_size.push_back(size_v[2:0]);
            vec_addr.push_back(addr_v);
            vec_wdata.push_back(wdata_v);
            vec_exp.push_back(exp_v);
            vec_level.push_back(hit_level_e'(lvl[1:0]));
        end
        $fclose(fd);
        if (vec_name.size() == 0) ok = 0;
    endtask

    // Present one access for a single cycle, return just after the sampling edge
    task automatic drive_access(input int i);
        access_i     = 1'b1;
        mem_write_i  = vec_write[i];
        size_src_i   = size_e'(vec_size[i]);
        addr_i       = vec_addr[i];
        write_data_i = vec_wdata[i];
        @(posedge clk);
        #DRIVE_DELAY;
        access_i    = 1'b0;
        mem_write_i = 1'b0;
    endtask

    task automatic check_read(input int i, output bit ok);
        hit_level_e exp_level;
        exp_level = vec_level[i];
        ok = 1;
        assert (data_valid_o === 1'b1) else begin
            $display("Test %0s: data_valid_o did not pulse in the cycle after the read",
                     vec_name[i]);
            ok = 0;
        end
        if (data_valid_o === 1'b1) begin
            assert (read_data_o === vec_exp[i]) else begin
                $display("CHECK FAILED %0s: read data expected %08h actual %08h",
                         vec_name[i], vec_exp[i], read_data_o);
                ok = 0;
            end
            assert (hit_level_o === exp_level) else begin
                $display("CHECK FAILED %0s: hit level expected %0s actual %0s",
                         vec_name[i], exp_level.name(), hit_level_o.name());
                ok = 0;
            end
        end
    endtask

    task automatic check_write(input int i, output bit ok);
        ok = 1;
        assert (data_valid_o === 1'b0) else begin
            $display("Test %0s: data_valid_o pulsed after a write", vec_name[i]);
            ok = 0;
        end
    endtask

    task automatic run_vectors();
        int gap;
        bit ok;
        for (int i = 0; i < vec_name.size(); i++) begin
            gap = int'($urandom % 3);               // Zero to two idle cycles
            if (is_back_to_back(vec_name[i])) gap = 0;
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            drive_access(i);
            if (vec_write[i]) check_write(i, ok);
            else check_read(i, ok);
            if (ok) begin
                pass_count++;
                $display("test %-12s passed", vec_name[i]);
            end else begin
                fail_count++;
                $display("test %-12s failed", vec_name[i]);
            end
        end
    endtask

    initial begin
        rst_n_i      = 1'b0;
        access_i     = 1'b0;
        mem_write_i  = 1'b0;
        size_src_i   = SIZE_W;
        addr_i       = '0;
        write_data_i = '0;
        void'($urandom(SEED));
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("Could not read usable vectors from %0s", VEC_FILE);
            $display("Result: FAILED");
            $finish;
        end else begin
            cycle_limit = vec_name.size() * 4 + 20;
            repeat (2) @(posedge clk);
            #DRIVE_DELAY;
            rst_n_i = 1'b1;
            run_vectors();
            $display("Tests run: %0d, passed: %0d, failed: %0d",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== testbench/access_input.txt ====
# name op size addr wdata expected level
# size 0 B, 1 H, 2 W, 4 BU, 5 HU; level L1 L2 L3 MEM, '-' on writes
cold_rd     R 2 00000100 00000000 00000000 MEM
warm_rd     R 2 00000100 00000000 00000000 L1
wr_word     W 2 00000200 81f27394 00000000 -
rd_word     R 2 00000200 00000000 81f27394 MEM
rd_b0       R 0 00000200 00000000 ffffff94 L1
rd_bu0      R 4 00000200 00000000 00000094 L1
rd_b1       R 0 00000201 00000000 00000073 L1
rd_bu1      R 4 00000201 00000000 00000073 L1
rd_b2       R 0 00000202 00000000 fffffff2 L1
rd_bu2      R 4 00000202 00000000 000000f2 L1
rd_b3       R 0 00000203 00000000 ffffff81 L1
rd_bu3      R 4 00000203 00000000 00000081 L1
rd_h0       R 1 00000200 00000000 00007394 L1
rd_hu0      R 5 00000200 00000000 00007394 L1
rd_h2       R 1 00000202 00000000 ffff81f2 L1
rd_hu2      R 5 00000202 00000000 000081f2 L1
upd_wr_b1   W 0 00000201 000000a5 00000000 -
upd_wr_h2   W 1 00000202 00003c5a 00000000 -
upd_rd_w    R 2 00000200 00000000 3c5aa594 L1
upd_rd_b1   R 0 00000201 00000000 ffffffa5 L1
upd_rd_hu2  R 5 00000202 00000000 00003c5a L1
conf_rd_b   R 2 00000210 00000000 00000000 MEM
conf_rd_a   R 2 00000200 00000000 3c5aa594 L2
conf_rd_b2  R 2 00000210 00000000 00000000 L2
conf3_wr_c  W 2 00000240 5eed1234 00000000 -
conf3_rd_c  R 2 00000240 00000000 5eed1234 MEM
conf3_rd_a  R 2 00000200 00000000 3c5aa594 L3
conf3_rd_c2 R 2 00000240 00000000 5eed1234 L3
nwa_wr      W 2 000003f8 13579bdf 00000000 -
nwa_rd      R 2 000003f8 00000000 13579bdf MEM
nwa_rd_bu3  R 4 000003fb 00000000 00000013 L1
b2b_rd0     R 2 000003f8 00000000 13579bdf L1
b2b_rd1     R 2 00000240 00000000 5eed1234 L1
b2b_rd2     R 1 00000242 00000000 00005eed L1
b2b_rd3     R 2 00000210 00000000 00000000 L2
b2b_rd4     R 2 00000210 00000000 00000000 L1
b2b_wr      W 2 000003f8 2468ace0 00000000 -
b2b_rd5     R 2 000003f8 00000000 2468ace0 L1
b2b_rd6     R 0 000003fc 00000000 00000000 MEM

// ==== compile.f ====
+incdir+hw
hw/mem_pkg.sv
hw/load_store_unit.sv
hw/cache_level.sv
hw/data_memory.sv
hw/memory_top.sv
testbench/tb_memory_top.sv

// ==== Makefile ====
# Verilator flow for the cache hierarchy testbench
VERILATOR ?= verilator
TOP       ?= tb_memory_top
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)
EXE     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the verdict
run: compile
	-./$(EXE) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || { echo "No verdict found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
